// File: rtl/icachePkg.sv
/*
 * Instruction cache package
 * Geometry constants and the storage types shared by the two-way cache
 */
package icachePkg;

    // Number of sets per way
    localparam int numSets = 4;

    // Words held in one cache block
    localparam int blockWords = 4;

    // Set index width
    localparam int setBits = $clog2(numSets);

    // Word offset width inside a block
    localparam int offsetBits = $clog2(blockWords);

    // Tag is what is left of the 30-bit word address
    // after the word offset and the set index
    localparam int tagBits = 30 - offsetBits - setBits;

    // Tag field of an address
    typedef logic [tagBits-1:0] tagT;

    // One tag store entry
    // Cleared valid bit means the way holds nothing
    typedef struct packed {
        logic valid;
        tagT  tag;
    } tagEntryT;

    // One cache block, word 0 in the lowest slot
    typedef logic [blockWords-1:0][31:0] blockT;

endpackage

// File: rtl/icacheArray.sv
/*
 * Cache storage array
 * One entry per set, read combinationally, written whole
 */
`timescale 1ns/100ps

module icacheArray #(
    // Payload kind, tag entries or data blocks
    parameter type entryT = logic [31:0]
) (
    input  logic                         clk,
    input  logic                         rstN,
    input  logic                         we,
    input  logic [icachePkg::setBits-1:0] idx,
    input  entryT                        wData,
    output entryT                        rData
);

    // Storage registers, one per set
    entryT mem [icachePkg::numSets];

    // Reset clears every entry
    // For tag arrays this drops all valid bits
    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < icachePkg::numSets; i++) begin
                mem[i] <= '0;
            end
        end else if (we) begin
            // Whole entry replaced on a fill
            mem[idx] <= wData;
        end
    end

    // Asynchronous read for the same-cycle hit path
    assign rData = mem[idx];

endmodule

// File: rtl/icacheLookup.sv
/*
 * Cache lookup
 * Splits the fetch address, checks both ways' tags and picks the hit word
 */
`timescale 1ns/100ps

module icacheLookup (
    input  logic [31:0]                    a,
    input  logic                           enable,
    input  icachePkg::tagEntryT            entry0,
    input  icachePkg::tagEntryT            entry1,
    input  icachePkg::blockT               block0,
    input  icachePkg::blockT               block1,
    output logic [icachePkg::setBits-1:0]  set,
    output icachePkg::tagT                 tag,
    output logic                           hit,
    output logic                           hitWay,
    output logic [31:0]                    rd
);

    // Word offset inside the block
    logic [icachePkg::offsetBits-1:0] offset;

    // Per-way tag match
    logic hit0;
    logic hit1;

    // Address fields
    // Byte offset in a[1:0] is ignored, fetches are word aligned
    assign offset = a[2 +: icachePkg::offsetBits];
    assign set    = a[2 + icachePkg::offsetBits +: icachePkg::setBits];
    assign tag    = a[31 -: icachePkg::tagBits];

    // Valid entry with equal tag
    assign hit0 = entry0.valid && (entry0.tag == tag);
    assign hit1 = entry1.valid && (entry1.tag == tag);

    // Hit is the raw match
    // The controller qualifies it with enable
    assign hit    = hit0 || hit1;
    assign hitWay = hit1;

    // Way mux then word mux
    always_comb begin
        if (hit1) begin
            rd = block1[offset];
        end else begin
            rd = block0[offset];
        end
    end

    // A block lives in one way only
    // Checked only for enabled fetches, the address is don't-care otherwise
    always_comb begin
        if (enable) begin
            assert final (!(hit0 && hit1))
                else $error("icacheLookup: tag hit in both ways for address %h", a);
        end
    end

endmodule

// File: rtl/icacheController.sv
/*
 * Cache miss controller
 * Lookup, refill and fill sequencing with one LRU bit per set
 */
`timescale 1ns/100ps

module icacheController (
    input  logic                          clk,
    input  logic                          rstN,
    input  logic                          enable,
    input  logic                          hit,
    input  logic                          hitWay,
    input  logic [icachePkg::setBits-1:0] set,
    input  logic                          refillDone,
    output logic                          iStall,
    output logic                          startRefill,
    output logic                          fillWay0,
    output logic                          fillWay1
);

    typedef enum logic [1:0] {
        sLookup,
        sRefill,
        sFill
    } stateT;

    stateT state;

    // LRU bit per set names the way to replace next
    logic [icachePkg::numSets-1:0] lru;

    // Way chosen for the block being fetched
    logic victimWay;

    // Enabled fetch that found nothing
    logic miss;

    assign miss = enable && !hit;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state       <= sLookup;
            lru         <= '0;
            victimWay   <= 1'b0;
            startRefill <= 1'b0;
        end else begin
            // Single-cycle pulse by default
            startRefill <= 1'b0;
            case (state)
                sLookup: begin
                    if (miss) begin
                        // Victim fixed now, hits cannot move it during refill
                        victimWay   <= lru[set];
                        startRefill <= 1'b1;
                        state       <= sRefill;
                    end else if (enable) begin
                        // Hit, the other way becomes least recent
                        lru[set] <= ~hitWay;
                    end
                end
                sRefill: begin
                    // Wait for the last bus word
                    if (refillDone) begin
                        state <= sFill;
                    end
                end
                sFill: begin
                    // Array written at this edge
                    // Fresh block is most recent
                    lru[set] <= ~victimWay;
                    state    <= sLookup;
                end
                default: begin
                    state <= sLookup;
                end
            endcase
        end
    end

    // Write strobes for the victim way
    assign fillWay0 = (state == sFill) && !victimWay;
    assign fillWay1 = (state == sFill) && victimWay;

    // Stall on a lookup miss and for the whole refill
    // An idle core never sees a stall
    assign iStall = enable && ((state != sLookup) || !hit);

    // Held fetch must hit the block just written
    assert property (@(posedge clk) disable iff (!rstN)
        ((state == sFill) && enable) |=> hit)
        else $error("icacheController: no hit after fill");

    // Bus side finishes only what this FSM started
    assert property (@(posedge clk) disable iff (!rstN)
        refillDone |-> (state == sRefill))
        else $error("icacheController: refillDone outside refill");

endmodule

// File: rtl/icacheRefill.sv
/*
 * Cache refill bus master
 * Requests the missing block word by word and assembles it for the arrays
 */
`timescale 1ns/100ps

module icacheRefill (
    input  logic                          clk,
    input  logic                          rstN,
    input  logic                          startRefill,
    input  icachePkg::tagT                tag,
    input  logic [icachePkg::setBits-1:0] set,
    input  logic                          busReady,
    input  logic [31:0]                   hRData,
    output logic                          hRequestF,
    output logic [31:0]                   hAddrF,
    output logic                          refillDone,
    output icachePkg::blockT              fillBlock
);

    // Request in progress
    logic active;

    // Word currently on the bus
    logic [icachePkg::offsetBits-1:0] wordIdx;

    // Block base captured at start
    icachePkg::tagT                baseTag;
    logic [icachePkg::setBits-1:0] baseSet;

    // Word accepted this cycle
    logic accept;
    logic lastWord;

    assign accept   = active && busReady;
    assign lastWord = (wordIdx == icachePkg::offsetBits'(icachePkg::blockWords - 1));

    // Control
    always_ff @(posedge clk) begin
        if (!rstN) begin
            active  <= 1'b0;
            wordIdx <= '0;
        end else if (startRefill) begin
            active  <= 1'b1;
            wordIdx <= '0;
        end else if (accept) begin
            // Counter wraps to zero after the last word
            wordIdx <= wordIdx + 1'b1;
            if (lastWord) begin
                active <= 1'b0;
            end
        end
    end

    // Block base and gathered words
    always_ff @(posedge clk) begin
        if (startRefill) begin
            baseTag <= tag;
            baseSet <= set;
        end
        if (accept) begin
            fillBlock[wordIdx] <= hRData;
        end
    end

    // Word-aligned bus address
    assign hAddrF    = {baseTag, baseSet, wordIdx, 2'b00};
    assign hRequestF = active;

    // Pulse with the last word, block is complete after this edge
    assign refillDone = accept && lastWord;

    // Address held until the slave takes it
    assert property (@(posedge clk) disable iff (!rstN)
        (hRequestF && !busReady) |=> (hRequestF && $stable(hAddrF)))
        else $error("icacheRefill: request changed without busReady");

endmodule

// File: rtl/icacheTop.sv
/*
 * Two-way set-associative instruction cache
 * Fetch side lookup, miss control, bus refill and the tag and data arrays
 */
`timescale 1ns/100ps

module icacheTop (
    input  logic        clk,
    input  logic        rstN,
    input  logic        enable,
    input  logic [31:0] a,
    output logic [31:0] rd,
    output logic        iStall,
    output logic        hRequestF,
    output logic [31:0] hAddrF,
    input  logic [31:0] hRData,
    input  logic        busReady
);

    // Lookup results
    logic [icachePkg::setBits-1:0] set;
    icachePkg::tagT                tag;
    logic                          hit;
    logic                          hitWay;

    // Array read data
    icachePkg::tagEntryT entry0;
    icachePkg::tagEntryT entry1;
    icachePkg::blockT    block0;
    icachePkg::blockT    block1;

    // Miss handshake
    logic startRefill;
    logic refillDone;

    // Fill path
    logic                fillWay0;
    logic                fillWay1;
    icachePkg::blockT    fillBlock;
    icachePkg::tagEntryT fillEntry;

    // New tag entry, address is held during the miss
    assign fillEntry = '{valid: 1'b1, tag: tag};

    icacheLookup iLookup (
        .a      (a),
        .enable (enable),
        .entry0 (entry0),
        .entry1 (entry1),
        .block0 (block0),
        .block1 (block1),
        .set    (set),
        .tag    (tag),
        .hit    (hit),
        .hitWay (hitWay),
        .rd     (rd)
    );

    icacheController iController (
        .clk         (clk),
        .rstN        (rstN),
        .enable      (enable),
        .hit         (hit),
        .hitWay      (hitWay),
        .set         (set),
        .refillDone  (refillDone),
        .iStall      (iStall),
        .startRefill (startRefill),
        .fillWay0    (fillWay0),
        .fillWay1    (fillWay1)
    );

    icacheRefill iRefill (
        .clk         (clk),
        .rstN        (rstN),
        .startRefill (startRefill),
        .tag         (tag),
        .set         (set),
        .busReady    (busReady),
        .hRData      (hRData),
        .hRequestF   (hRequestF),
        .hAddrF      (hAddrF),
        .refillDone  (refillDone),
        .fillBlock   (fillBlock)
    );

    // Way 0 tags and data
    icacheArray #(.entryT(icachePkg::tagEntryT)) iTag0 (
        .clk   (clk),
        .rstN  (rstN),
        .we    (fillWay0),
        .idx   (set),
        .wData (fillEntry),
        .rData (entry0)
    );

    icacheArray #(.entryT(icachePkg::blockT)) iData0 (
        .clk   (clk),
        .rstN  (rstN),
        .we    (fillWay0),
        .idx   (set),
        .wData (fillBlock),
        .rData (block0)
    );

    // Way 1 tags and data
    icacheArray #(.entryT(icachePkg::tagEntryT)) iTag1 (
        .clk   (clk),
        .rstN  (rstN),
        .we    (fillWay1),
        .idx   (set),
        .wData (fillEntry),
        .rData (entry1)
    );

    icacheArray #(.entryT(icachePkg::blockT)) iData1 (
        .clk   (clk),
        .rstN  (rstN),
        .we    (fillWay1),
        .idx   (set),
        .wData (fillBlock),
        .rData (block1)
    );

endmodule

// File: sim/busMemModel.sv
/*
 * Bus memory model
 * Answers refill requests after a chosen number of wait cycles
 */
`timescale 1ns/100ps

module busMemModel (
    input  logic        clk,
    input  logic        rstN,
    input  logic        hRequestF,
    input  logic [31:0] hAddrF,
    input  logic [1:0]  waitCycles,
    output logic        busReady,
    output logic [31:0] hRData
);

    // Cycles the current word has waited so far
    logic [1:0] waited;

    // Memory image, inverted low address half over the low address half
    function automatic logic [31:0] memWord(input logic [31:0] addr);
        return {~addr[15:0], addr[15:0]};
    endfunction

    always_ff @(posedge clk) begin
        if (!rstN) begin
            waited <= 2'd0;
        end else if (!hRequestF || busReady) begin
            // Next word starts a fresh wait
            waited <= 2'd0;
        end else begin
            waited <= waited + 2'd1;
        end
    end

    // Ready once the wait is used up
    // Compare with >= so a lowered wait count still ends the wait
    assign busReady = hRequestF && (waited >= waitCycles);

    // Data only meaningful in the ready cycle
    assign hRData = busReady ? memWord(hAddrF) : 32'h0;

endmodule

// File: sim/icacheTb.sv
/*
 * Instruction cache testbench
 * Fetch sequences against the cache and a bus memory model, checked by assertions
 */
`timescale 1ns/100ps

module icacheTb;

    logic        clk;
    logic        rstN;
    logic        enable;
    logic [31:0] a;
    logic [31:0] rd;
    logic        iStall;
    logic        hRequestF;
    logic [31:0] hAddrF;
    logic [31:0] hRData;
    logic        busReady;

    // Random or zero bus wait for the next word
    logic [1:0]  waitCycles;
    logic        randomWaits;

    // LFSR state and the words taken from it
    logic [31:0] lfsr = 32'h709b962a;
    logic [31:0] waitBits;
    logic [31:0] randWord;
    logic [31:0] base;

    int    errors = 0;
    int    testErrors;
    int    testsRun = 0;
    int    testsFailed = 0;
    string testName;

    icacheTop i_dut (.*);

    busMemModel iMem (.*);

    always #50 clk = ~clk;

    // Memory rule with the inverted low half over the low half of the byte address
    function automatic logic [31:0] expectedWord(input logic [31:0] x);
        return {~x[15:0], x[15:0]};
    endfunction

    function automatic int wordOffset(input logic [31:0] x);
        return int'(x[31:2]) % icachePkg::blockWords;
    endfunction

    // Word w of the block holding x
    function automatic logic [31:0] withWord(input logic [31:0] x, input int w);
        return (x & ~((32'(icachePkg::blockWords) << 2) - 32'd1)) | (32'(w) << 2);
    endfunction

    // Same set, different tag
    function automatic logic [31:0] otherTag(input logic [31:0] x, input int n);
        return x ^ (32'(n) << (2 + icachePkg::offsetBits + icachePkg::setBits));
    endfunction

    function automatic logic [31:0] otherSet(input logic [31:0] x, input int n);
        return x ^ (32'(n) << (2 + icachePkg::offsetBits));
    endfunction

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] lfsrStep(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // One LFSR step per bit
    task automatic takeBits(input int n, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < n; i++) begin
            lfsr  = lfsrStep(lfsr);
            value = {value[30:0], lfsr[0]};
        end
    endtask

    task automatic reportTimeout(input string what);
        errors++;
        $display("Timeout in test %s: %s", testName, what);
    endtask

    task automatic checkLevel(input string name, input logic got, input logic want);
        assert (got === want) else begin
            errors++;
            $display("[ERROR] %s: got %h expected %h at a=%h", name, got, want, a);
        end
    endtask

    // Starts 1 ns after a rising edge, returns 1 ns after the completing edge
    task automatic fetch(input logic [31:0] addr, input logic expectHit);
        int waited;
        enable = 1'b1;
        a      = addr;
        @(negedge clk);
        checkLevel("iStall", iStall, !expectHit);
        if (expectHit) begin
            checkLevel("hRequestF", hRequestF, 1'b0);
        end
        waited = 0;
        while (iStall && waited < 100) begin
            @(negedge clk);
            waited++;
        end
        if (iStall) begin
            reportTimeout("iStall never fell");
        end
        @(posedge clk);
        #1;
    endtask

    task automatic beginTest(input string name);
        testName   = name;
        testErrors = errors;
    endtask

    task automatic endTest();
        testsRun++;
        if (errors == testErrors) begin
            $display("Test %s: pass", testName);
        end else begin
            testsFailed++;
            $display("Test %s: FAIL with %0d errors", testName, errors - testErrors);
        end
    endtask

    // Completed fetch returns the memory word
    assert property (@(posedge clk) disable iff (!rstN)
        (enable && !iStall) |-> (rd == expectedWord(a)))
        else begin
            errors++;
            $display("[ERROR] rd: got %h expected %h at a=%h",
                $sampled(rd), expectedWord($sampled(a)), $sampled(a));
        end

    // Refill opens on word 0 of the missing block
    assert property (@(posedge clk) disable iff (!rstN)
        $rose(hRequestF) |-> (hAddrF == withWord(a, 0)))
        else begin
            errors++;
            $display("[ERROR] hAddrF: got %h expected %h",
                $sampled(hAddrF), withWord($sampled(a), 0));
        end

    // Each accepted word is followed by the next one up
    assert property (@(posedge clk) disable iff (!rstN)
        (hRequestF && busReady && wordOffset(hAddrF) != icachePkg::blockWords - 1)
            |=> (hRequestF && hAddrF == $past(hAddrF) + 32'd4))
        else begin
            errors++;
            $display("[ERROR] hAddrF: got %h, not the next word", $sampled(hAddrF));
        end

    // Held while the slave is not ready
    assert property (@(posedge clk) disable iff (!rstN)
        (hRequestF && !busReady) |=> (hRequestF && $stable(hAddrF)))
        else begin
            errors++;
            $display("[ERROR] hAddrF: changed to %h without busReady", $sampled(hAddrF));
        end

    // Idle core sees no stall and no bus traffic
    assert property (@(posedge clk) disable iff (!rstN)
        !enable |-> (!iStall && !hRequestF))
        else begin
            errors++;
            $display("[ERROR] iStall/hRequestF: got %h/%h expected 0/0 with enable low",
                $sampled(iStall), $sampled(hRequestF));
        end

    // New wait count after each accepted word
    always @(posedge clk) begin
        if (rstN && hRequestF && busReady) begin
            #1;
            if (randomWaits) begin
                takeBits(2, waitBits);
                waitCycles = waitBits[1:0];
            end else begin
                waitCycles = 2'd0;
            end
        end
    end

    initial begin
        clk         = 1'b0;
        rstN        = 1'b0;
        enable      = 1'b0;
        a           = '0;
        waitCycles  = '0;
        randomWaits = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        rstN = 1'b1;
        takeBits(32, base);
        base = base & ~32'h3;

        beginTest("cold miss");
        fetch(base, 1'b0);
        endTest();

        beginTest("hit");
        for (int w = 1; w < icachePkg::blockWords; w++) begin
            fetch(withWord(base, w), 1'b1);
        end
        endTest();

        beginTest("two ways");
        fetch(otherTag(base, 1), 1'b0);
        fetch(base, 1'b1);
        fetch(otherTag(base, 1), 1'b1);
        endTest();

        // A B A C, then C has replaced B
        beginTest("lru eviction");
        fetch(base, 1'b1);
        fetch(otherTag(base, 1), 1'b1);
        fetch(base, 1'b1);
        fetch(otherTag(base, 2), 1'b0);
        fetch(base, 1'b1);
        fetch(otherTag(base, 1), 1'b0);
        endTest();

        // Still empty sets, filled under random bus waits
        beginTest("back-pressure");
        randomWaits = 1'b1;
        for (int s = 1; s < icachePkg::numSets; s++) begin
            fetch(otherSet(base, s), 1'b0);
            for (int w = 0; w < icachePkg::blockWords; w++) begin
                fetch(withWord(otherSet(base, s), w), 1'b1);
            end
        end
        randomWaits = 1'b0;
        endTest();

        beginTest("idle");
        enable = 1'b0;
        repeat (8) begin
            takeBits(32, randWord);
            a = randWord & ~32'h3;
            @(posedge clk);
            #1;
        end
        endTest();

        $display("Tests run %0d, failed %0d, errors %0d", testsRun, testsFailed, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// File: sim.f
rtl/icachePkg.sv
rtl/icacheArray.sv
rtl/icacheLookup.sv
rtl/icacheController.sv
rtl/icacheRefill.sv
rtl/icacheTop.sv
sim/busMemModel.sv
sim/icacheTb.sv

// File: run.sh
#!/usr/bin/env bash
# Build the cache testbench with Verilator, run it and scan the log
set -o pipefail
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/100ps \
    -f sim.f --top-module icacheTb -Mdir obj_dir \
    && ./obj_dir/VicacheTb | tee sim.log \
    || { echo "Build or simulation error"; exit 1; }
grep -q "Something failed" sim.log && { echo "Simulation failed"; exit 1; } \
    || { echo "Simulation passed"; exit 0; }
